// ==== hdl/ppu_apb_regs.sv ====
// PPU APB register slave
module ppu_apb_regs
  import ppu_pkg::*;
(
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         psel,
  input  logic                                         penable,
  input  logic                                         pwrite,
  input  logic [APB_AW-1:0]                            paddr,
  input  logic [APB_DW-1:0]                            pwdata,
  output logic [APB_DW-1:0]                            prdata,
  output logic                                         pready,
  output logic                                         pslverr,
  input  logic                                         busy,
  input  logic                                         done,
  input  logic [ROW_W:0]                               reuse_count,
  input  logic [ACC_W-1:0]                             res_data,
  output logic                                         start,
  output logic [ROWS-1:0][SPIKES-1:0]                  tile_rows,
  output logic [SPIKES-1:0][PE_COUNT-1:0][WEIGHT_W-1:0] weights,
  output logic [ROW_W-1:0]                             res_row,
  output logic [PE_W-1:0]                              res_pe
);

  ppu_wdata_u wdata;
  logic       setup;
  logic       access_wr;
  logic       wr_err;
  logic       hit_ctrl;
  logic       hit_status;
  logic       hit_reuse;
  logic       hit_tile;
  logic       hit_wgt;
  logic       hit_res;

  // ========================================
  // Address decode
  // ========================================
  assign hit_ctrl   = (paddr == ADDR_CTRL);
  assign hit_status = (paddr == ADDR_STATUS);
  assign hit_reuse  = (paddr == ADDR_REUSE);
  assign hit_tile   = (paddr >= TILE_BASE) && (paddr < TILE_BASE + 4 * ROWS);
  assign hit_wgt    = (paddr >= WGT_BASE) && (paddr < WGT_BASE + 4 * SPIKES);
  assign hit_res    = (paddr >= RES_BASE) && (paddr < RES_BASE + 4 * ROWS * PE_COUNT);

  // Result index is r*PE_COUNT + p, word aligned
  assign res_pe  = paddr[2 +: PE_W];
  assign res_row = paddr[2 + PE_W +: ROW_W];

  // No wait states
  assign pready = 1'b1;

  // Error judged in setup phase, reported in access phase
  assign setup  = psel && !penable;
  assign wr_err = pwrite && busy && (hit_tile || hit_wgt || (hit_ctrl && pwdata[0]));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pslverr <= 1'b0;
    end else begin
      pslverr <= setup && wr_err;
    end
  end

  // Rejected writes leave storage alone
  assign access_wr = psel && penable && pwrite && !pslverr;
  assign wdata     = pwdata;
  assign start     = access_wr && hit_ctrl && wdata.tile_view[0];

  // Pattern and weight storage
  always_ff @(posedge clk) begin
    if (access_wr && hit_tile) begin
      tile_rows[paddr[2 +: ROW_W]] <= wdata.tile_view[SPIKES-1:0];
    end
    if (access_wr && hit_wgt) begin
      weights[paddr[2 +: SPK_W]] <= wdata.wgt_view;
    end
  end

  // Read mux, unmapped reads give 0
  always_comb begin
    prdata = '0;
    if (hit_status) begin
      prdata[1:0] = {done, busy};
    end else if (hit_reuse) begin
      prdata[ROW_W:0] = reuse_count;
    end else if (hit_res) begin
      prdata[ACC_W-1:0] = res_data;
    end
  end

  // Error only shows with the access phase
  a_slverr_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> psel && penable);

endmodule

// ==== hdl/ppu_dispatcher.sv ====
// PPU dispatcher buffer
module ppu_dispatcher
  import ppu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              prn_valid,
  input  logic [ROW_W-1:0]  prn_row,
  input  logic [ROW_W-1:0]  prn_prefix,
  input  logic              prn_has_prefix,
  input  logic [SPIKES-1:0] prn_residual,
  input  logic              task_ready,
  output logic              dsp_ready,
  output logic              task_valid,
  output logic [ROW_W-1:0]  task_row,
  output logic [ROW_W-1:0]  task_prefix,
  output logic              task_has_prefix,
  output logic [SPIKES-1:0] task_residual
);

  // Two entries, in issue order
  logic [ROW_W-1:0]  row_q      [2];
  logic [ROW_W-1:0]  prefix_q   [2];
  logic              has_q      [2];
  logic [SPIKES-1:0] residual_q [2];
  logic              wr_ptr;
  logic              rd_ptr;
  logic [1:0]        count;
  logic              push;
  logic              pop;

  assign dsp_ready  = (count != 2'd2);
  assign task_valid = (count != 2'd0);
  assign push       = prn_valid && dsp_ready;
  assign pop        = task_valid && task_ready;

  // Head entry
  assign task_row        = row_q[rd_ptr];
  assign task_prefix     = prefix_q[rd_ptr];
  assign task_has_prefix = has_q[rd_ptr];
  assign task_residual   = residual_q[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      row_q[wr_ptr]      <= prn_row;
      prefix_q[wr_ptr]   <= prn_prefix;
      has_q[wr_ptr]      <= prn_has_prefix;
      residual_q[wr_ptr] <= prn_residual;
    end
  end

  // Full buffer takes no push and the pruner keeps its row
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    (count == 2'd2) && prn_valid |=> prn_valid && $stable(prn_row));

endmodule

// ==== hdl/ppu_pkg.sv ====
// PPU shared definitions
package ppu_pkg;

  // ========================================
  // Sizes and widths
  // ========================================
  localparam int ROWS     = 8;
  localparam int ROW_W    = 3;
  localparam int SPIKES   = 8;
  localparam int SPK_W    = 3;
  localparam int NO_W     = 4;
  localparam int PE_COUNT = 4;
  localparam int PE_W     = 2;
  localparam int WEIGHT_W = 8;
  localparam int ACC_W    = 16;
  localparam int APB_AW   = 12;
  localparam int APB_DW   = 32;

  // ========================================
  // APB address map
  // ========================================
  localparam logic [APB_AW-1:0] ADDR_CTRL   = 12'h000;
  localparam logic [APB_AW-1:0] ADDR_STATUS = 12'h004;
  localparam logic [APB_AW-1:0] ADDR_REUSE  = 12'h008;
  localparam logic [APB_AW-1:0] TILE_BASE   = 12'h040;
  localparam logic [APB_AW-1:0] WGT_BASE    = 12'h080;
  localparam logic [APB_AW-1:0] RES_BASE    = 12'h100;

  // Tile controller states
  localparam logic [1:0] TC_IDLE  = 2'd0;
  localparam logic [1:0] TC_ISSUE = 2'd1;
  localparam logic [1:0] TC_DRAIN = 2'd2;

  // Processor states
  localparam logic [1:0] PR_IDLE  = 2'd0;
  localparam logic [1:0] PR_LOAD  = 2'd1;
  localparam logic [1:0] PR_ACC   = 2'd2;
  localparam logic [1:0] PR_WRITE = 2'd3;

  // APB write word, view picked by address region
  typedef union packed {
    logic [APB_DW-1:0]                 tile_view;
    logic [PE_COUNT-1:0][WEIGHT_W-1:0] wgt_view;
  } ppu_wdata_u;

endpackage

// ==== hdl/ppu_prefix_pruner.sv ====
// PPU prefix pruner
module ppu_prefix_pruner
  import ppu_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        si_valid,
  input  logic [ROWS-1:0]             si_vec,
  input  logic [ROW_W-1:0]            si_row,
  input  logic [ROWS-1:0][SPIKES-1:0] tile_rows,
  input  logic                        dsp_ready,
  output logic                        det_ready,
  output logic                        prn_valid,
  output logic [ROW_W-1:0]            prn_row,
  output logic [ROW_W-1:0]            prn_prefix,
  output logic                        prn_has_prefix,
  output logic [SPIKES-1:0]           prn_residual
);

  logic [ROW_W-1:0]  best;
  logic [NO_W-1:0]   best_pc;
  logic              found;
  logic [SPIKES-1:0] query;
  logic [SPIKES-1:0] prefix_pat;

  function automatic logic [NO_W-1:0] popcount(input logic [SPIKES-1:0] v);
    logic [NO_W-1:0] n;
    n = '0;
    for (int i = 0; i < SPIKES; i++) begin
      n = n + v[i];
    end
    return n;
  endfunction

  // ========================================
  // Best prefix
  // ========================================
  // Strict compare keeps the lowest index on a tie
  always_comb begin
    best    = '0;
    best_pc = '0;
    found   = 1'b0;
    for (int k = 0; k < ROWS; k++) begin
      if (si_vec[k] && (!found || popcount(tile_rows[k]) > best_pc)) begin
        found   = 1'b1;
        best    = ROW_W'(k);
        best_pc = popcount(tile_rows[k]);
      end
    end
  end

  assign query      = tile_rows[si_row];
  assign prefix_pat = found ? tile_rows[best] : '0;
  assign det_ready  = !prn_valid || dsp_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prn_valid <= 1'b0;
    end else if (si_valid && det_ready) begin
      prn_valid <= 1'b1;
    end else if (dsp_ready) begin
      prn_valid <= 1'b0;
    end
  end

  // Prefix is a subset, so XOR leaves only the missing bits
  always_ff @(posedge clk) begin
    if (si_valid && det_ready) begin
      prn_row        <= si_row;
      prn_prefix     <= best;
      prn_has_prefix <= found;
      prn_residual   <= query ^ prefix_pat;
    end
  end

  // Pruning never adds work
  a_residual_le: assert property (@(posedge clk) disable iff (!rst_n)
    prn_valid |-> $countones(prn_residual) <= $countones(tile_rows[prn_row]));

endmodule

// ==== hdl/ppu_processor.sv ====
// PPU row processor
module ppu_processor
  import ppu_pkg::*;
(
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         task_valid,
  input  logic [ROW_W-1:0]                             task_row,
  input  logic [ROW_W-1:0]                             task_prefix,
  input  logic                                         task_has_prefix,
  input  logic [SPIKES-1:0]                            task_residual,
  input  logic [SPIKES-1:0][PE_COUNT-1:0][WEIGHT_W-1:0] weights,
  input  logic [ROW_W-1:0]                             res_row,
  input  logic [PE_W-1:0]                              res_pe,
  output logic                                         task_ready,
  output logic                                         row_done,
  output logic [ACC_W-1:0]                             res_data
);

  logic [1:0]                     state;
  logic [ROW_W-1:0]               cur_row;
  logic [ROW_W-1:0]               cur_prefix;
  logic                           cur_has;
  logic [SPIKES-1:0]              rem;
  logic [SPIKES-1:0]              rem_next;
  logic [SPK_W-1:0]               bit_idx;
  logic [PE_COUNT-1:0][ACC_W-1:0] acc;
  // Result memory, one word of all PEs per row
  logic [PE_COUNT-1:0][ACC_W-1:0] res_mem [ROWS];

  function automatic logic [SPK_W-1:0] lowest_set(input logic [SPIKES-1:0] v);
    logic [SPK_W-1:0] idx;
    idx = '0;
    for (int i = SPIKES - 1; i >= 0; i--) begin
      if (v[i]) begin
        idx = SPK_W'(i);
      end
    end
    return idx;
  endfunction

  assign task_ready = (state == PR_IDLE);
  assign row_done   = (state == PR_WRITE);
  assign bit_idx    = lowest_set(rem);
  // Drop the bit being added
  assign rem_next   = rem & (rem - 1'b1);
  assign res_data   = res_mem[res_row][res_pe];

  // ========================================
  // Control
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= PR_IDLE;
    end else begin
      case (state)
        PR_IDLE:  if (task_valid) state <= PR_LOAD;
        PR_LOAD:  state <= (rem == '0) ? PR_WRITE : PR_ACC;
        PR_ACC:   if (rem_next == '0) state <= PR_WRITE;
        default:  state <= PR_IDLE;
      endcase
    end
  end

  // ========================================
  // Datapath
  // ========================================
  always_ff @(posedge clk) begin
    case (state)
      PR_IDLE: begin
        if (task_valid) begin
          cur_row    <= task_row;
          cur_prefix <= task_prefix;
          cur_has    <= task_has_prefix;
          rem        <= task_residual;
        end
      end
      // Prefix row always finished earlier
      PR_LOAD: acc <= cur_has ? res_mem[cur_prefix] : '0;
      PR_ACC: begin
        for (int p = 0; p < PE_COUNT; p++) begin
          acc[p] <= acc[p] + ACC_W'(weights[bit_idx][p]);
        end
        rem <= rem_next;
      end
      default: res_mem[cur_row] <= acc;
    endcase
  end

endmodule

// ==== hdl/ppu_subset_detector.sv ====
// PPU subset detector
module ppu_subset_detector
  import ppu_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        q_valid,
  input  logic [ROW_W-1:0]            q_row,
  input  logic [ROWS-1:0][SPIKES-1:0] tile_rows,
  input  logic                        det_ready,
  output logic                        q_ready,
  output logic                        si_valid,
  output logic [ROWS-1:0]             si_vec,
  output logic [ROW_W-1:0]            si_row
);

  logic [ROWS-1:0] subset;

  // Takes a query when the output slot is free or leaving
  assign q_ready = !si_valid || det_ready;

  // Row k qualifies if earlier and no bit outside the query
  always_comb begin
    for (int k = 0; k < ROWS; k++) begin
      subset[k] = (k < q_row) && ((tile_rows[k] & ~tile_rows[q_row]) == '0);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      si_valid <= 1'b0;
    end else if (q_valid && q_ready) begin
      si_valid <= 1'b1;
    end else if (det_ready) begin
      si_valid <= 1'b0;
    end
  end

  // Result held while the pruner stalls
  always_ff @(posedge clk) begin
    if (q_valid && q_ready) begin
      si_vec <= subset;
      si_row <= q_row;
    end
  end

endmodule

// ==== hdl/ppu_tile_ctrl.sv ====
// PPU tile controller
module ppu_tile_ctrl
  import ppu_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  logic             q_ready,
  input  logic             row_done,
  input  logic             prn_valid,
  input  logic             dsp_ready,
  input  logic             prn_has_prefix,
  output logic             q_valid,
  output logic [ROW_W-1:0] q_row,
  output logic             busy,
  output logic             done,
  output logic [ROW_W:0]   reuse_count
);

  logic [1:0]     state;
  logic [ROW_W:0] done_cnt;

  assign q_valid = (state == TC_ISSUE);
  assign busy    = (state != TC_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= TC_IDLE;
      q_row       <= '0;
      done_cnt    <= '0;
      done        <= 1'b0;
      reuse_count <= '0;
    end else begin
      // Finished rows, counted in any busy state
      if (row_done) begin
        done_cnt <= done_cnt + 1'b1;
      end
      // Rows leaving the pruner with a prefix
      if (prn_valid && dsp_ready && prn_has_prefix) begin
        reuse_count <= reuse_count + 1'b1;
      end
      case (state)
        TC_IDLE: begin
          // New tile clears counters and sticky done
          if (start) begin
            state       <= TC_ISSUE;
            q_row       <= '0;
            done_cnt    <= '0;
            reuse_count <= '0;
            done        <= 1'b0;
          end
        end
        TC_ISSUE: begin
          if (q_ready) begin
            if (q_row == ROW_W'(ROWS - 1)) begin
              state <= TC_DRAIN;
            end else begin
              q_row <= q_row + 1'b1;
            end
          end
        end
        TC_DRAIN: begin
          // Wait for every row to come back
          if (done_cnt == (ROW_W + 1)'(ROWS)) begin
            state <= TC_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= TC_IDLE;
      endcase
    end
  end

  // Processor only finishes rows of a running tile
  a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
    row_done |-> busy);

endmodule

// ==== hdl/ppu_top.sv ====
// PPU top level
module ppu_top
  import ppu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_AW-1:0] paddr,
  input  logic [APB_DW-1:0] pwdata,
  output logic [APB_DW-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  // ========================================
  // Register side
  // ========================================
  logic                                         start;
  logic                                         busy;
  logic                                         done;
  logic [ROW_W:0]                               reuse_count;
  logic [ACC_W-1:0]                             res_data;
  logic [ROWS-1:0][SPIKES-1:0]                  tile_rows;
  logic [SPIKES-1:0][PE_COUNT-1:0][WEIGHT_W-1:0] weights;
  logic [ROW_W-1:0]                             res_row;
  logic [PE_W-1:0]                              res_pe;

  // ========================================
  // Pipeline handshakes
  // ========================================
  logic              q_valid;
  logic              q_ready;
  logic [ROW_W-1:0]  q_row;
  logic              si_valid;
  logic [ROWS-1:0]   si_vec;
  logic [ROW_W-1:0]  si_row;
  logic              det_ready;
  logic              prn_valid;
  logic [ROW_W-1:0]  prn_row;
  logic [ROW_W-1:0]  prn_prefix;
  logic              prn_has_prefix;
  logic [SPIKES-1:0] prn_residual;
  logic              dsp_ready;
  logic              task_valid;
  logic [ROW_W-1:0]  task_row;
  logic [ROW_W-1:0]  task_prefix;
  logic              task_has_prefix;
  logic [SPIKES-1:0] task_residual;
  logic              task_ready;
  logic              row_done;

  // Port names match the wires above
  ppu_apb_regs        u_regs       (.*);
  ppu_tile_ctrl       u_tile_ctrl  (.*);
  ppu_subset_detector u_detector   (.*);
  ppu_prefix_pruner   u_pruner     (.*);
  ppu_dispatcher      u_dispatcher (.*);
  ppu_processor       u_processor  (.*);

endmodule

// ==== ppu.f ====
hdl/ppu_pkg.sv
hdl/ppu_apb_regs.sv
hdl/ppu_tile_ctrl.sv
hdl/ppu_subset_detector.sv
hdl/ppu_prefix_pruner.sv
hdl/ppu_dispatcher.sv
hdl/ppu_processor.sv
hdl/ppu_top.sv
test/ppu_clk_gen.sv
test/ppu_tb.sv

// ==== test/ppu_clk_gen.sv ====
// PPU testbench clock and reset
module ppu_clk_gen (
  output logic clk,
  output logic rst_n
);

  // Period 20
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held low for 3 cycles
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== test/ppu_tb.sv ====
// PPU directed testbench
module ppu_tb
  import ppu_pkg::*;
();

  localparam int POLL_LIMIT = 200;

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;

  // Reference copy of the loaded tile and weights
  logic [SPIKES-1:0]   tile_m [ROWS];
  logic [WEIGHT_W-1:0] wgt_m  [SPIKES][PE_COUNT];
  integer              seed;

  ppu_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  ppu_top dut_i (.*);

  // ========================================
  // Failure handling and compares
  // ========================================
  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic compare_result(input logic [ACC_W-1:0] got, input logic [ACC_W-1:0] exp,
                                input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
      stop_run();
    end
  endtask

  task automatic compare_count(input logic [ROW_W:0] got, input logic [ROW_W:0] exp,
                               input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s reuse got %0d expected %0d", $time, msg, got, exp);
      stop_run();
    end
  endtask

  task automatic compare_status(input logic [1:0] got, input logic [1:0] exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s status got %b expected %b", $time, msg, got, exp);
      stop_run();
    end
  endtask

  task automatic check_slverr(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s pslverr got %b expected %b", $time, msg, got, exp);
      stop_run();
    end
  endtask

  // ========================================
  // APB master
  // ========================================
  // Response sampled at the falling edge of the access phase
  task automatic apb_transfer(input logic is_write, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata,
                              output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= is_write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    if (pready !== 1'b1) begin
      $display("APB slave did not signal ready in the access phase at %0t", $time);
      stop_run();
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                           output logic err);
    logic [APB_DW-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                          output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  // ========================================
  // Reference model
  // ========================================
  function automatic logic [ACC_W-1:0] model_sum(input int r, input int p);
    logic [ACC_W-1:0] sum;
    sum = '0;
    for (int s = 0; s < SPIKES; s++) begin
      if (tile_m[r][s]) begin
        sum = sum + ACC_W'(wgt_m[s][p]);
      end
    end
    return sum;
  endfunction

  // Rows with any earlier subset row
  function automatic logic [ROW_W:0] model_reuse();
    logic [ROW_W:0] n;
    logic           hit;
    n = '0;
    for (int r = 0; r < ROWS; r++) begin
      hit = 1'b0;
      for (int k = 0; k < r; k++) begin
        if ((tile_m[k] & ~tile_m[r]) == '0) begin
          hit = 1'b1;
        end
      end
      n = n + hit;
    end
    return n;
  endfunction

  task automatic random_weights();
    logic [31:0] rnd;
    for (int s = 0; s < SPIKES; s++) begin
      for (int p = 0; p < PE_COUNT; p++) begin
        rnd         = $random(seed);
        wgt_m[s][p] = rnd[WEIGHT_W-1:0];
      end
    end
  endtask

  // ========================================
  // Tile helpers
  // ========================================
  task automatic load_tile();
    logic [APB_DW-1:0] word;
    logic              err;
    for (int r = 0; r < ROWS; r++) begin
      apb_write(TILE_BASE + APB_AW'(4 * r), APB_DW'(tile_m[r]), err);
      check_slverr(err, 1'b0, "tile write");
    end
    for (int s = 0; s < SPIKES; s++) begin
      word = '0;
      for (int p = 0; p < PE_COUNT; p++) begin
        word[WEIGHT_W * p +: WEIGHT_W] = wgt_m[s][p];
      end
      apb_write(WGT_BASE + APB_AW'(4 * s), word, err);
      check_slverr(err, 1'b0, "weight write");
    end
  endtask

  // Poll done with a bounded number of reads
  task automatic wait_done(input string name);
    logic [APB_DW-1:0] rd;
    logic              err;
    int                polls;
    rd    = '0;
    polls = 0;
    while (rd[1] !== 1'b1 && polls < POLL_LIMIT) begin
      apb_read(ADDR_STATUS, rd, err);
      polls++;
    end
    if (rd[1] !== 1'b1) begin
      $display("Timeout in %s: done bit not set after %0d status reads", name, POLL_LIMIT);
      stop_run();
    end
    compare_status(rd[1:0], 2'b10, name);
  endtask

  task automatic run_tile(input string name);
    logic err;
    apb_write(ADDR_CTRL, 32'h1, err);
    check_slverr(err, 1'b0, name);
    wait_done(name);
  endtask

  task automatic check_tile(input string name);
    logic [APB_DW-1:0] rd;
    logic              err;
    for (int r = 0; r < ROWS; r++) begin
      for (int p = 0; p < PE_COUNT; p++) begin
        apb_read(RES_BASE + APB_AW'(4 * (r * PE_COUNT + p)), rd, err);
        compare_result(rd[ACC_W-1:0], model_sum(r, p),
                       $sformatf("%s row %0d pe %0d", name, r, p));
      end
    end
    apb_read(ADDR_REUSE, rd, err);
    compare_count(rd[ROW_W:0], model_reuse(), name);
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic test_reset();
    logic [APB_DW-1:0] rd;
    logic              err;
    apb_read(ADDR_STATUS, rd, err);
    compare_status(rd[1:0], 2'b00, "after reset");
    // Gap between weight and result regions
    apb_read(12'h0FC, rd, err);
    check_slverr(err, 1'b0, "unmapped read");
    compare_result(rd[ACC_W-1:0], '0, "unmapped read data");
    compare_result(rd[APB_DW-1:ACC_W], '0, "unmapped read upper data");
  endtask

  task automatic test_no_subset();
    for (int r = 0; r < ROWS; r++) begin
      tile_m[r] = SPIKES'(1) << r;
    end
    random_weights();
    load_tile();
    run_tile("one hot");
    check_tile("one hot");
  endtask

  // Each row one bit wider than the last
  task automatic test_nested();
    for (int r = 0; r < ROWS; r++) begin
      tile_m[r] = (SPIKES'(1) << (r + 1)) - 1'b1;
    end
    load_tile();
    run_tile("nested");
    check_tile("nested");
  endtask

  task automatic test_tie();
    tile_m[0] = 8'h03;
    tile_m[1] = 8'h0C;
    tile_m[2] = 8'h0F;
    tile_m[3] = 8'h0F;
    tile_m[4] = 8'h30;
    tile_m[5] = 8'h30;
    tile_m[6] = 8'hC0;
    tile_m[7] = 8'h3F;
    random_weights();
    load_tile();
    run_tile("tie");
    check_tile("tie");
  endtask

  task automatic test_busy_errors();
    logic [APB_DW-1:0] rd;
    logic              err;
    // Distinct rows of equal popcount give long rows and no prefix
    tile_m[0] = 8'h0F;
    tile_m[1] = 8'h33;
    tile_m[2] = 8'h55;
    tile_m[3] = 8'h3C;
    tile_m[4] = 8'h5A;
    tile_m[5] = 8'h66;
    tile_m[6] = 8'h96;
    tile_m[7] = 8'hF0;
    random_weights();
    load_tile();
    apb_write(ADDR_CTRL, 32'h1, err);
    check_slverr(err, 1'b0, "busy start");
    // Old done cleared by the start
    apb_read(ADDR_STATUS, rd, err);
    compare_status(rd[1:0], 2'b01, "busy start");
    // Last row is not yet read by the pipeline
    apb_write(TILE_BASE + APB_AW'(4 * (ROWS - 1)), 32'hFF, err);
    check_slverr(err, 1'b1, "tile write while busy");
    apb_write(ADDR_CTRL, 32'h1, err);
    check_slverr(err, 1'b1, "start while busy");
    wait_done("busy");
    check_tile("busy");
  endtask

  task automatic test_random();
    logic [31:0] rnd;
    string       name;
    for (int t = 0; t < 3; t++) begin
      name = $sformatf("random %0d", t);
      for (int r = 0; r < ROWS; r++) begin
        rnd       = $random(seed);
        tile_m[r] = rnd[SPIKES-1:0];
      end
      random_weights();
      load_tile();
      run_tile(name);
      check_tile(name);
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    int cycles;
    seed    = 32'h7844;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    cycles  = 0;
    while (rst_n !== 1'b1 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was never released");
      stop_run();
    end
    test_reset();
    test_no_subset();
    test_nested();
    test_tie();
    test_busy_errors();
    test_random();
    $display("all tests passed");
    $finish;
  end

endmodule
